// ==== Makefile ====
# Verilator flow for the router tile

VERILATOR ?= verilator
TOP       ?= router_tile_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/router_tile_props.sv ====
// Router tile handshake assertions
`timescale 1ns/1ps

module router_tile_props import noc_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  // Mesh output links
  input flit_t north_out,
  input logic  north_out_valid,
  input logic  north_out_ready,
  input flit_t south_out,
  input logic  south_out_valid,
  input logic  south_out_ready,
  input flit_t east_out,
  input logic  east_out_valid,
  input logic  east_out_ready,
  input flit_t west_out,
  input logic  west_out_valid,
  input logic  west_out_ready,
  // Local transmit link
  input logic  tx_busy,
  input logic  local_ready
);

  // ----------------------------------------------------------------------
  // Offered flit stays until taken
  // ----------------------------------------------------------------------
  a_north_hold: assert property (@(posedge clk) disable iff (!rst_n)
    north_out_valid && !north_out_ready |=> north_out_valid && $stable(north_out))
    else $error("north_out dropped or changed a pending flit");

  a_south_hold: assert property (@(posedge clk) disable iff (!rst_n)
    south_out_valid && !south_out_ready |=> south_out_valid && $stable(south_out))
    else $error("south_out dropped or changed a pending flit");

  a_east_hold: assert property (@(posedge clk) disable iff (!rst_n)
    east_out_valid && !east_out_ready |=> east_out_valid && $stable(east_out))
    else $error("east_out dropped or changed a pending flit");

  a_west_hold: assert property (@(posedge clk) disable iff (!rst_n)
    west_out_valid && !west_out_ready |=> west_out_valid && $stable(west_out))
    else $error("west_out dropped or changed a pending flit");

  // ----------------------------------------------------------------------
  // Local transmit and reset
  // ----------------------------------------------------------------------

  // Busy until the router local FIFO takes the flit
  a_tx_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
    tx_busy && !local_ready |=> tx_busy)
    else $error("tx_busy fell before the local transfer");

  // Mesh outputs quiet in reset
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !(north_out_valid || south_out_valid || east_out_valid || west_out_valid))
    else $error("out valid high during reset");

endmodule

// ==== dv/router_tile_tb.sv ====
// Router tile testbench
`timescale 1ns/1ps
`include "noc_params.svh"

module router_tile_tb import noc_pkg::*; ();

  localparam coord_t tile_x = 2'd1;
  localparam coord_t tile_y = 2'd1;
  localparam int timeout_cycles = 500;

  // One table row, stall enables random ready drops on the routed output
  typedef struct packed {
    port_sel_t src;
    coord_t    dest_x;
    coord_t    dest_y;
    payload_t  payload;
    logic      stall;
  } entry_t;

  logic                clk;
  logic                rst_n;
  // Port-indexed views of the DUT links, index 0 is the PE side
  flit_t [n_ports-1:0] in_flit_v;
  logic  [n_ports-1:0] in_valid_v;
  logic  [n_ports-1:0] in_ready_v;
  flit_t [n_ports-1:0] out_flit_v;
  logic  [n_ports-1:0] out_valid_v;
  logic  [n_ports-1:0] out_rdy_v;
  logic                tx_wr;
  pe_tx_t              tx_req;
  logic                tx_busy;
  logic                rx_rd;

  // Output ready control, written on rising edges only
  logic [n_ports-1:0]  hold;
  logic [n_ports-1:0]  stall_en;

  logic [31:0]         rng_state = 32'h83ab_eb20;
  entry_t              table_q [$];
  entry_t              lat_row;
  int                  route_end;
  int                  bp_end;
  // Scoreboard, one queue per output and source pair
  flit_t               exp_q [n_ports*n_ports][$];

  assign in_ready_v[port_local] = !tx_busy;

  // ----------------------------------------------------------------------
  // DUT and bound assertions
  // ----------------------------------------------------------------------
  router_tile #(
    .TILE_X(tile_x),
    .TILE_Y(tile_y)
  ) u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .north_in       (in_flit_v[port_north]),
    .north_in_valid (in_valid_v[port_north]),
    .north_in_ready (in_ready_v[port_north]),
    .north_out      (out_flit_v[port_north]),
    .north_out_valid(out_valid_v[port_north]),
    .north_out_ready(out_rdy_v[port_north]),
    .south_in       (in_flit_v[port_south]),
    .south_in_valid (in_valid_v[port_south]),
    .south_in_ready (in_ready_v[port_south]),
    .south_out      (out_flit_v[port_south]),
    .south_out_valid(out_valid_v[port_south]),
    .south_out_ready(out_rdy_v[port_south]),
    .east_in        (in_flit_v[port_east]),
    .east_in_valid  (in_valid_v[port_east]),
    .east_in_ready  (in_ready_v[port_east]),
    .east_out       (out_flit_v[port_east]),
    .east_out_valid (out_valid_v[port_east]),
    .east_out_ready (out_rdy_v[port_east]),
    .west_in        (in_flit_v[port_west]),
    .west_in_valid  (in_valid_v[port_west]),
    .west_in_ready  (in_ready_v[port_west]),
    .west_out       (out_flit_v[port_west]),
    .west_out_valid (out_valid_v[port_west]),
    .west_out_ready (out_rdy_v[port_west]),
    .tx_wr          (tx_wr),
    .tx_req         (tx_req),
    .tx_busy        (tx_busy),
    .rx_rd          (rx_rd),
    .rx_flit        (out_flit_v[port_local]),
    .rx_valid       (out_valid_v[port_local])
  );

  bind router_tile router_tile_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .north_out      (north_out),
    .north_out_valid(north_out_valid),
    .north_out_ready(north_out_ready),
    .south_out      (south_out),
    .south_out_valid(south_out_valid),
    .south_out_ready(south_out_ready),
    .east_out       (east_out),
    .east_out_valid (east_out_valid),
    .east_out_ready (east_out_ready),
    .west_out       (west_out),
    .west_out_valid (west_out_valid),
    .west_out_ready (west_out_ready),
    .tx_busy        (tx_busy),
    .local_ready    (r_in_ready[noc_pkg::port_local])
  );

  // ----------------------------------------------------------------------
  // Reporting and compare tasks
  // ----------------------------------------------------------------------
  task automatic stop_run();
    $display("Something failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout at time %0t: %s did not happen within %0d cycles",
             $time, what, timeout_cycles);
    stop_run();
  endtask

  task automatic check_flit(input string name, input flit_t act, input flit_t exp);
    if (act !== exp) begin
      $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, act, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("CHECK FAILED at time %0t: %s is %b, expected %b", $time, name, act, exp);
      stop_run();
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  // Xorshift32, single generator for the whole run
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // X first, then Y, equal goes to the PE
  function automatic port_sel_t expect_port(coord_t dx, coord_t dy);
    if (dx > tile_x) return port_east;
    if (dx < tile_x) return port_west;
    if (dy > tile_y) return port_north;
    if (dy < tile_y) return port_south;
    return port_local;
  endfunction

  function automatic string port_name(port_sel_t p);
    case (p)
      port_north: return "north";
      port_south: return "south";
      port_east:  return "east";
      port_west:  return "west";
      default:    return "local";
    endcase
  endfunction

  // Top 3 payload bits tag the source port for the scoreboard
  function automatic entry_t make_entry(port_sel_t src, coord_t dx, coord_t dy, logic stall);
    logic [31:0] r;
    entry_t      e;
    r         = next_rand();
    e.src     = src;
    e.dest_x  = dx;
    e.dest_y  = dy;
    e.stall   = stall;
    e.payload = {src, r[12:0]};
    return e;
  endfunction

  // Flit as it must leave the tile
  function automatic flit_t entry_flit(entry_t e);
    flit_t f;
    f.dest_x  = e.dest_x;
    f.dest_y  = e.dest_y;
    f.src_x   = (e.src == port_local) ? tile_x : 2'd0;
    f.src_y   = (e.src == port_local) ? tile_y : 2'd0;
    f.payload = e.payload;
    return f;
  endfunction

  task automatic push_expect(input entry_t e);
    int k;
    k = int'(expect_port(e.dest_x, e.dest_y)) * n_ports + int'(e.src);
    exp_q[k].push_back(entry_flit(e));
  endtask

  function automatic int pending_count();
    int n;
    n = 0;
    for (int k = 0; k < n_ports * n_ports; k++) begin
      n += exp_q[k].size();
    end
    return n;
  endfunction

  // Match one delivered flit against the oldest from its source
  task automatic take_flit(input port_sel_t o, input flit_t f);
    int src;
    int k;
    src = int'(f.payload[$bits(payload_t)-1 -: 3]);
    k   = int'(o) * n_ports + src;
    if (src >= n_ports || exp_q[k].size() == 0) begin
      $display("Unexpected flit %h delivered on the %s output", f, port_name(o));
      stop_run();
    end else begin
      check_flit({port_name(o), " output flit"}, f, exp_q[k].pop_front());
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus tasks, all entered on a falling edge
  // ----------------------------------------------------------------------
  task automatic drive_tx(input entry_t e);
    tx_req.dest_x  = e.dest_x;
    tx_req.dest_y  = e.dest_y;
    tx_req.payload = e.payload;
    tx_wr = 1'b1;
    @(negedge clk);
    tx_wr = 1'b0;
  endtask

  task automatic send_entry(input entry_t e);
    int n;
    push_expect(e);
    n = 0;
    if (e.src == port_local) begin
      while (tx_busy) begin
        @(negedge clk);
        n++;
        if (n > timeout_cycles) timeout_fail("free local transmit slot");
      end
      drive_tx(e);
    end else begin
      in_flit_v[e.src]  = entry_flit(e);
      in_valid_v[e.src] = 1'b1;
      // Ready depends on FIFO state only, so it holds until the edge
      while (!in_ready_v[e.src]) begin
        @(negedge clk);
        n++;
        if (n > timeout_cycles) timeout_fail({port_name(e.src), " input acceptance"});
      end
      @(negedge clk);
      in_valid_v[e.src] = 1'b0;
    end
  endtask

  // Stall mode changes on the rising edge, the ready driver reads it later
  task automatic apply_entry(input entry_t e);
    @(posedge clk);
    stall_en[expect_port(e.dest_x, e.dest_y)] = e.stall;
    @(negedge clk);
    send_entry(e);
  endtask

  task automatic run_rows(input int first, input int last);
    for (int i = first; i < last; i++) begin
      apply_entry(table_q[i]);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pending_count() != 0) begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) timeout_fail("delivery of all expected flits");
    end
  endtask

  task automatic check_reset();
    for (int p = 1; p < n_ports; p++) begin
      check_bit({port_name(port_sel_t'(p)), "_out_valid"}, out_valid_v[p], 1'b0);
      check_bit({port_name(port_sel_t'(p)), "_in_ready"}, in_ready_v[p], 1'b1);
    end
    check_bit("rx_valid", out_valid_v[port_local], 1'b0);
    check_bit("tx_busy", tx_busy, 1'b0);
  endtask

  task automatic build_table();
    coord_t      dx_list [7];
    coord_t      dy_list [7];
    logic [31:0] r;
    // East, west, north, south, local and two far corners
    dx_list = '{2'd2, 2'd0, 2'd1, 2'd1, 2'd1, 2'd3, 2'd0};
    dy_list = '{2'd1, 2'd1, 2'd2, 2'd0, 2'd1, 2'd0, 2'd3};
    for (int s = 0; s < n_ports; s++) begin
      for (int d = 0; d < 7; d++) begin
        table_q.push_back(make_entry(port_sel_t'(s), dx_list[d], dy_list[d], 1'b0));
      end
    end
    route_end = table_q.size();
    // West to east, enough to fill the west FIFO
    for (int i = 0; i < `NOC_FIFO_DEPTH; i++) begin
      table_q.push_back(make_entry(port_west, 2'd3, coord_t'(i), 1'b0));
    end
    bp_end = table_q.size();
    // Every source aims at east, then random traffic
    for (int i = 0; i < 2 * n_ports; i++) begin
      table_q.push_back(make_entry(port_sel_t'(i % n_ports), 2'd2, 2'd2, 1'b1));
    end
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      table_q.push_back(make_entry(port_sel_t'(r % 32'd5), r[9:8], r[11:10], 1'b1));
    end
    lat_row = make_entry(port_local, 2'd2, 2'd1, 1'b0);
  endtask

  // PE write to east output, uncontended and ready
  task automatic local_latency();
    flit_t exp;
    exp = entry_flit(lat_row);
    push_expect(lat_row);
    drive_tx(lat_row);
    check_bit("tx_busy", tx_busy, 1'b1);
    check_bit("east_out_valid", out_valid_v[port_east], 1'b0);
    @(negedge clk);
    check_bit("east_out_valid", out_valid_v[port_east], 1'b1);
    check_flit("east_out", out_flit_v[port_east], exp);
    check_bit("tx_busy", tx_busy, 1'b0);
  endtask

  // ----------------------------------------------------------------------
  // Clock, output side and main sequence
  // ----------------------------------------------------------------------
  initial begin : clock_gen
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Readies and rx_rd on the falling edge, then record the coming transfers
  initial begin : out_side
    logic [31:0] r;
    logic        rd_last;
    out_rdy_v = '0;
    rx_rd     = 1'b0;
    rd_last   = 1'b0;
    forever begin
      @(negedge clk);
      if (rd_last) check_bit("rx_valid after rx_rd", out_valid_v[port_local], 1'b0);
      r = next_rand();
      for (int o = 0; o < n_ports; o++) begin
        out_rdy_v[o] = !hold[o] && !(stall_en[o] && r[o]);
      end
      rx_rd   = out_valid_v[port_local] && out_rdy_v[port_local];
      rd_last = rx_rd;
      for (int o = 0; o < n_ports; o++) begin
        if (out_valid_v[o] && out_rdy_v[o]) take_flit(port_sel_t'(o), out_flit_v[o]);
      end
    end
  end

  initial begin : main_seq
    rst_n      = 1'b1;
    in_flit_v  = '0;
    in_valid_v = '0;
    tx_wr      = 1'b0;
    tx_req     = '0;
    hold       = '0;
    stall_en   = '0;
    build_table();
    #1 rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    check_reset();
    rst_n = 1'b1;
    @(negedge clk);
    check_reset();

    // XY routing from every source
    run_rows(0, route_end);
    wait_drain();

    // Two-cycle transmit path
    local_latency();
    wait_drain();

    // East held low, west FIFO fills, then drains in order
    @(posedge clk);
    hold[port_east] = 1'b1;
    @(negedge clk);
    run_rows(route_end, bp_end);
    check_bit("west_in_ready", in_ready_v[port_west], 1'b0);
    check_bit("east_out_valid", out_valid_v[port_east], 1'b1);
    @(posedge clk);
    hold[port_east] = 1'b0;
    @(negedge clk);
    wait_drain();

    // Contention and random traffic under stalls
    run_rows(bp_end, table_q.size());
    @(posedge clk);
    stall_en = '0;
    @(negedge clk);
    wait_drain();

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== hdl/flit_fifo.sv ====
// Router input FIFO
`timescale 1ns/1ps
`include "noc_params.svh"

module flit_fifo import noc_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // Write side
  input  flit_t in_flit,
  input  logic  in_valid,
  output logic  in_ready,
  // Read side
  output flit_t out_flit,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int depth = `NOC_FIFO_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  // Storage and bookkeeping
  flit_t            mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             push;
  logic             pop;

  // Pointer advance with wrap at the last entry
  function automatic logic [ptr_w-1:0] ptr_inc(logic [ptr_w-1:0] p);
    if (p == ptr_w'(depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // Full only at depth entries
  assign in_ready  = (count != (ptr_w+1)'(depth));
  assign out_valid = (count != '0);
  // Head is visible the cycle after it is written
  assign out_flit  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Pointers and occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Simultaneous push and pop leaves count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_flit;
    end
  end

endmodule

// ==== hdl/net_iface.sv ====
// Local network interface
`timescale 1ns/1ps

module net_iface import noc_pkg::*; #(
  parameter coord_t TILE_X = '0,
  parameter coord_t TILE_Y = '0
) (
  input  logic   clk,
  input  logic   rst_n,
  // Processing element transmit
  input  logic   tx_wr,
  input  pe_tx_t tx_req,
  output logic   tx_busy,
  // Processing element receive
  input  logic   rx_rd,
  output flit_t  rx_flit,
  output logic   rx_valid,
  // Toward the router local input
  output flit_t  to_router,
  output logic   to_router_valid,
  input  logic   to_router_ready,
  // From the router local output
  input  flit_t  from_router,
  input  logic   from_router_valid,
  output logic   from_router_ready
);

  ni_tx_state_e tx_state;
  flit_t        tx_flit;
  logic         tx_take;
  logic         rx_take;

  // ----------------------------------------------------------------------
  // Transmit path
  // ----------------------------------------------------------------------

  // Write strobe counts only while idle
  assign tx_take = tx_wr && (tx_state == idle);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_state <= idle;
    end else begin
      case (tx_state)
        idle: begin
          if (tx_wr) begin
            tx_state <= wait_accept;
          end
        end
        wait_accept: begin
          // Router took the flit
          if (to_router_ready) begin
            tx_state <= idle;
          end
        end
        default: tx_state <= idle;
      endcase
    end
  end

  // Source fields carry this tile
  always_ff @(posedge clk) begin
    if (tx_take) begin
      tx_flit.dest_x  <= tx_req.dest_x;
      tx_flit.dest_y  <= tx_req.dest_y;
      tx_flit.src_x   <= TILE_X;
      tx_flit.src_y   <= TILE_Y;
      tx_flit.payload <= tx_req.payload;
    end
  end

  assign to_router       = tx_flit;
  assign to_router_valid = (tx_state == wait_accept);
  assign tx_busy         = (tx_state == wait_accept);

  // ----------------------------------------------------------------------
  // Receive path
  // ----------------------------------------------------------------------

  // Single slot, blocked while occupied
  assign from_router_ready = !rx_valid;
  assign rx_take           = from_router_valid && from_router_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_valid <= 1'b0;
    end else if (rx_take) begin
      rx_valid <= 1'b1;
    end else if (rx_rd) begin
      rx_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rx_take) begin
      rx_flit <= from_router;
    end
  end

endmodule

// ==== hdl/noc_params.svh ====
// NoC tile parameters
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// ----------------------------------------------------------------------
// Mesh geometry
// ----------------------------------------------------------------------

// Bits per X or Y coordinate, enough for a 4x4 mesh
`define NOC_COORD_W 2

// ----------------------------------------------------------------------
// Flit and buffer sizing
// ----------------------------------------------------------------------

// Payload bits carried by every single-flit packet
`define NOC_PAYLOAD_W 16

// Entries in each router input FIFO
`define NOC_FIFO_DEPTH 4

`endif

// ==== hdl/noc_pkg.sv ====
// NoC tile types
`include "noc_params.svh"

package noc_pkg;

  // ----------------------------------------------------------------------
  // Scalar types
  // ----------------------------------------------------------------------

  // One mesh coordinate
  typedef logic [`NOC_COORD_W-1:0] coord_t;

  // Flit payload
  typedef logic [`NOC_PAYLOAD_W-1:0] payload_t;

  // Router port index
  typedef logic [2:0] port_sel_t;

  // Port count and port encoding
  localparam int n_ports = 5;
  localparam port_sel_t port_local = 3'd0;
  localparam port_sel_t port_north = 3'd1;
  localparam port_sel_t port_south = 3'd2;
  localparam port_sel_t port_east  = 3'd3;
  localparam port_sel_t port_west  = 3'd4;

  // ----------------------------------------------------------------------
  // Structs and enums
  // ----------------------------------------------------------------------

  // Single flit on every link
  typedef struct packed {
    coord_t   dest_x;
    coord_t   dest_y;
    coord_t   src_x;
    coord_t   src_y;
    payload_t payload;
  } flit_t;

  // Send request from the processing element
  typedef struct packed {
    coord_t   dest_x;
    coord_t   dest_y;
    payload_t payload;
  } pe_tx_t;

  // Network interface transmit FSM
  typedef enum logic [0:0] {
    idle,
    wait_accept
  } ni_tx_state_e;

endpackage

// ==== hdl/router_tile.sv ====
// Mesh tile with router and NI
`timescale 1ns/1ps

module router_tile import noc_pkg::*; #(
  parameter coord_t TILE_X = '0,
  parameter coord_t TILE_Y = '0
) (
  input  logic   clk,
  input  logic   rst_n,
  // North links
  input  flit_t  north_in,
  input  logic   north_in_valid,
  output logic   north_in_ready,
  output flit_t  north_out,
  output logic   north_out_valid,
  input  logic   north_out_ready,
  // South links
  input  flit_t  south_in,
  input  logic   south_in_valid,
  output logic   south_in_ready,
  output flit_t  south_out,
  output logic   south_out_valid,
  input  logic   south_out_ready,
  // East links
  input  flit_t  east_in,
  input  logic   east_in_valid,
  output logic   east_in_ready,
  output flit_t  east_out,
  output logic   east_out_valid,
  input  logic   east_out_ready,
  // West links
  input  flit_t  west_in,
  input  logic   west_in_valid,
  output logic   west_in_ready,
  output flit_t  west_out,
  output logic   west_out_valid,
  input  logic   west_out_ready,
  // Processing element side
  input  logic   tx_wr,
  input  pe_tx_t tx_req,
  output logic   tx_busy,
  input  logic   rx_rd,
  output flit_t  rx_flit,
  output logic   rx_valid
);

  // Router side port arrays
  flit_t r_in_flit   [n_ports];
  logic  r_in_valid  [n_ports];
  logic  r_in_ready  [n_ports];
  flit_t r_out_flit  [n_ports];
  logic  r_out_valid [n_ports];
  logic  r_out_ready [n_ports];

  // ----------------------------------------------------------------------
  // Mesh side mapping
  // ----------------------------------------------------------------------
  assign r_in_flit[port_north]   = north_in;
  assign r_in_valid[port_north]  = north_in_valid;
  assign north_in_ready          = r_in_ready[port_north];
  assign north_out               = r_out_flit[port_north];
  assign north_out_valid         = r_out_valid[port_north];
  assign r_out_ready[port_north] = north_out_ready;

  assign r_in_flit[port_south]   = south_in;
  assign r_in_valid[port_south]  = south_in_valid;
  assign south_in_ready          = r_in_ready[port_south];
  assign south_out               = r_out_flit[port_south];
  assign south_out_valid         = r_out_valid[port_south];
  assign r_out_ready[port_south] = south_out_ready;

  assign r_in_flit[port_east]    = east_in;
  assign r_in_valid[port_east]   = east_in_valid;
  assign east_in_ready           = r_in_ready[port_east];
  assign east_out                = r_out_flit[port_east];
  assign east_out_valid          = r_out_valid[port_east];
  assign r_out_ready[port_east]  = east_out_ready;

  assign r_in_flit[port_west]    = west_in;
  assign r_in_valid[port_west]   = west_in_valid;
  assign west_in_ready           = r_in_ready[port_west];
  assign west_out                = r_out_flit[port_west];
  assign west_out_valid          = r_out_valid[port_west];
  assign r_out_ready[port_west]  = west_out_ready;

  // ----------------------------------------------------------------------
  // Router and local interface
  // ----------------------------------------------------------------------
  xy_router #(
    .ROUTER_X(TILE_X),
    .ROUTER_Y(TILE_Y)
  ) u_router (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_flit  (r_in_flit),
    .in_valid (r_in_valid),
    .in_ready (r_in_ready),
    .out_flit (r_out_flit),
    .out_valid(r_out_valid),
    .out_ready(r_out_ready)
  );

  // Local link runs through the array slots of port 0
  net_iface #(
    .TILE_X(TILE_X),
    .TILE_Y(TILE_Y)
  ) u_ni (
    .clk              (clk),
    .rst_n            (rst_n),
    .tx_wr            (tx_wr),
    .tx_req           (tx_req),
    .tx_busy          (tx_busy),
    .rx_rd            (rx_rd),
    .rx_flit          (rx_flit),
    .rx_valid         (rx_valid),
    .to_router        (r_in_flit[port_local]),
    .to_router_valid  (r_in_valid[port_local]),
    .to_router_ready  (r_in_ready[port_local]),
    .from_router      (r_out_flit[port_local]),
    .from_router_valid(r_out_valid[port_local]),
    .from_router_ready(r_out_ready[port_local])
  );

endmodule

// ==== hdl/rr_arbiter.sv ====
// Output port round-robin arbiter
`timescale 1ns/1ps

module rr_arbiter import noc_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  // One request per input port
  input  logic [n_ports-1:0] req,
  // Output transfer done
  input  logic               advance,
  output port_sel_t          grant,
  output logic               grant_valid
);

  // Priority pointer and grant lock
  port_sel_t prio;
  port_sel_t held;
  logic      locked;
  port_sel_t pick;
  logic      found;

  // ----------------------------------------------------------------------
  // Search from the priority pointer
  // ----------------------------------------------------------------------
  always_comb begin
    int idx;
    pick  = prio;
    found = 1'b0;
    for (int i = 0; i < n_ports; i++) begin
      idx = int'(prio) + i;
      if (idx >= n_ports) begin
        idx = idx - n_ports;
      end
      // First requester wins
      if (!found && req[idx]) begin
        pick  = port_sel_t'(idx);
        found = 1'b1;
      end
    end
  end

  // Stalled output keeps its winner
  assign grant       = locked ? held : pick;
  assign grant_valid = locked ? req[held] : found;

  // ----------------------------------------------------------------------
  // Pointer and lock update
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio   <= port_local;
      held   <= port_local;
      locked <= 1'b0;
    end else if (advance) begin
      // Priority moves past the winner
      locked <= 1'b0;
      if (int'(grant) == n_ports - 1) begin
        prio <= port_sel_t'(0);
      end else begin
        prio <= grant + 1'b1;
      end
    end else if (grant_valid) begin
      // Granted but not taken yet
      locked <= 1'b1;
      held   <= grant;
    end
  end

endmodule

// ==== hdl/xy_router.sv ====
// Five-port XY mesh router
`timescale 1ns/1ps

module xy_router import noc_pkg::*; #(
  parameter coord_t ROUTER_X = '0,
  parameter coord_t ROUTER_Y = '0
) (
  input  logic  clk,
  input  logic  rst_n,
  // Input links
  input  flit_t in_flit   [n_ports],
  input  logic  in_valid  [n_ports],
  output logic  in_ready  [n_ports],
  // Output links
  output flit_t out_flit  [n_ports],
  output logic  out_valid [n_ports],
  input  logic  out_ready [n_ports]
);

  // FIFO heads
  flit_t              head        [n_ports];
  logic               head_valid  [n_ports];
  logic               head_pop    [n_ports];
  port_sel_t          route       [n_ports];
  // Per output arbitration, req is indexed output then input
  logic [n_ports-1:0] req         [n_ports];
  port_sel_t          grant       [n_ports];
  logic               grant_valid [n_ports];
  logic               advance     [n_ports];

  // X first, then Y
  function automatic port_sel_t xy_route(flit_t f);
    port_sel_t dir;
    if (f.dest_x > ROUTER_X) begin
      dir = port_east;
    end else if (f.dest_x < ROUTER_X) begin
      dir = port_west;
    end else if (f.dest_y > ROUTER_Y) begin
      dir = port_north;
    end else if (f.dest_y < ROUTER_Y) begin
      dir = port_south;
    end else begin
      dir = port_local;
    end
    return dir;
  endfunction

  // ----------------------------------------------------------------------
  // Route compute and request matrix
  // ----------------------------------------------------------------------
  always_comb begin
    for (int o = 0; o < n_ports; o++) begin
      req[o] = '0;
    end
    for (int i = 0; i < n_ports; i++) begin
      route[i] = xy_route(head[i]);
      if (head_valid[i]) begin
        req[route[i]][i] = 1'b1;
      end
    end
  end

  // Head leaves when its output transfers it
  always_comb begin
    for (int i = 0; i < n_ports; i++) begin
      head_pop[i] = grant_valid[route[i]] &&
                    (grant[route[i]] == port_sel_t'(i)) &&
                    out_ready[route[i]];
    end
  end

  // ----------------------------------------------------------------------
  // Per port buffer, arbiter and crossbar leg
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < n_ports; p++) begin : g_port
    flit_fifo u_fifo (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_flit  (in_flit[p]),
      .in_valid (in_valid[p]),
      .in_ready (in_ready[p]),
      .out_flit (head[p]),
      .out_valid(head_valid[p]),
      .out_ready(head_pop[p])
    );

    rr_arbiter u_arb (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req[p]),
      .advance    (advance[p]),
      .grant      (grant[p]),
      .grant_valid(grant_valid[p])
    );

    // Crossbar select from the granted head
    assign out_flit[p]  = head[grant[p]];
    assign out_valid[p] = grant_valid[p];
    assign advance[p]   = grant_valid[p] && out_ready[p];
  end

endmodule

// ==== list.f ====
+incdir+hdl
hdl/noc_pkg.sv
hdl/flit_fifo.sv
hdl/rr_arbiter.sv
hdl/xy_router.sv
hdl/net_iface.sv
hdl/router_tile.sv
dv/router_tile_props.sv
dv/router_tile_tb.sv
